// ==== project.f ====
+incdir+include
verilog/async_fifo_pkg.sv
verilog/fifo_mem_if.sv
verilog/dualport_ram_async.sv
verilog/fifo_wr_ctrl.sv
verilog/fifo_rd_ctrl.sv
verilog/async_fifo.sv
dv/async_fifo_tb.sv

// ==== Makefile ====
# Verilator build and run for the dual-clock FIFO

VERILATOR ?= verilator
TOP       ?= async_fifo_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^Simulation PASSED$$" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/async_fifo_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "async_fifo_defs.svh"

module async_fifo_tb import async_fifo_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4000;  // wr_clk cycles, about three times the test length
  localparam int STREAM_CYCLES  = 500;
  localparam int SETTLE_CYCLES  = 5;     // rd_clk is the slower clock

  logic        wr_clk;
  logic        rd_clk;
  logic        wr_rst_n;
  logic        rd_rst_n;
  logic        wr_en;
  logic        rd_en;
  fifo_data_t  wr_data;
  fifo_data_t  rd_data;
  logic        full;
  logic        afull;
  logic        empty;
  logic        aempty;

  integer      seed;
  int          data_errs;
  int          flag_errs;
  int          count_errs;
  int          other_errs;
  int          cycle_cnt;
  fifo_data_t  ref_q[$];     // Words accepted but not yet read
  fifo_data_t  exp_word;
  logic        rd_pending;
  logic [31:0] wr_rand [STREAM_CYCLES];
  logic [31:0] rd_rand [STREAM_CYCLES];

  async_fifo async_fifo_inst (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #2 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #3 rd_clk = ~rd_clk;
  end

  task automatic check_data(input fifo_data_t got, input fifo_data_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("FAILED at %0t: rd_data is 0x%0h, expected 0x%0h", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      flag_errs++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input fifo_ptr_t got, input fifo_ptr_t exp);
    if (got !== exp) begin
      count_errs++;
      $display("FAILED at %0t: %0d words outstanding, expected %0d", $time, got, exp);
    end
  endtask

  // Accepted writes enter the reference queue
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      ref_q.push_back(wr_data);
    end
  end

  // Word read at one edge is checked at the next
  always @(posedge rd_clk) begin
    if (rd_pending) begin
      check_data(rd_data, exp_word);
    end
    rd_pending = 1'b0;
    if (rd_rst_n && rd_en && !empty) begin
      if (ref_q.size() == 0) begin
        other_errs++;
        $display("DUT accepted a read at %0t although no word was written", $time);
      end else begin
        exp_word   = ref_q.pop_front();
        rd_pending = 1'b1;
      end
    end
  end

  task automatic settle();
    repeat (SETTLE_CYCLES) @(posedge rd_clk);
  endtask

  task automatic write_burst(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge wr_clk);
      wr_en   <= 1'b1;
      wr_data <= fifo_data_t'($random(seed));
    end
    @(posedge wr_clk);
    wr_en <= 1'b0;
  endtask

  task automatic read_burst(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge rd_clk);
      rd_en <= 1'b1;
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
  endtask

  task automatic drain_fifo();
    @(posedge rd_clk);
    rd_en <= 1'b1;
    @(posedge rd_clk);
    while (!empty) @(posedge rd_clk);
    rd_en <= 1'b0;
  endtask

  task automatic check_levels(input int count);
    check_count(fifo_ptr_t'(ref_q.size()), fifo_ptr_t'(count));
    check_flag(afull, (count >= `FIFO_AFULL_LEVEL), "afull");
    check_flag(aempty, (count <= `FIFO_AEMPTY_LEVEL), "aempty");
    check_flag(full, (count == `FIFO_DEPTH), "full");
    check_flag(empty, (count == 0), "empty");
  endtask

  task automatic test_reset();
    check_flag(empty, 1'b1, "empty");
    check_flag(aempty, 1'b1, "aempty");
    check_flag(full, 1'b0, "full");
    check_flag(afull, 1'b0, "afull");
    check_data(rd_data, fifo_data_t'(0));
  endtask

  task automatic test_fill();
    write_burst(`FIFO_DEPTH);
    while (!full) @(posedge wr_clk);
    settle();
    check_levels(`FIFO_DEPTH);
    write_burst(1);  // Dropped by the DUT and by the queue model
    settle();
    check_levels(`FIFO_DEPTH);
  endtask

  task automatic test_drain();
    drain_fifo();
    settle();
    check_levels(0);
    read_burst(1);
    settle();
    check_data(rd_data, exp_word);  // Read on empty must not touch rd_data
    check_levels(0);
  endtask

  task automatic test_thresholds();
    for (int c = 0; c <= `FIFO_DEPTH; c++) begin
      check_levels(c);
      if (c < `FIFO_DEPTH) begin
        write_burst(1);
        settle();
      end
    end
    for (int c = `FIFO_DEPTH; c > 0; c--) begin
      read_burst(1);
      settle();
      check_levels(c - 1);
    end
  endtask

  task automatic test_stream();
    for (int i = 0; i < STREAM_CYCLES; i++) begin
      wr_rand[i] = $random(seed);
      rd_rand[i] = $random(seed);
    end
    fork
      begin
        for (int i = 0; i < STREAM_CYCLES; i++) begin
          @(posedge wr_clk);
          wr_en   <= wr_rand[i][0];
          wr_data <= fifo_data_t'(wr_rand[i][31:8]);
        end
        @(posedge wr_clk);
        wr_en <= 1'b0;
      end
      begin
        for (int i = 0; i < STREAM_CYCLES; i++) begin
          @(posedge rd_clk);
          rd_en <= |rd_rand[i][1:0];  // Reads slightly favored
        end
        @(posedge rd_clk);
        rd_en <= 1'b0;
      end
    join
    settle();
    drain_fifo();
    settle();
    check_levels(0);
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge wr_clk);
      cycle_cnt++;
    end
    $display("Run stopped after %0d wr_clk cycles without finishing", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed       = 32'h3cef9baa;
    data_errs  = 0;
    flag_errs  = 0;
    count_errs = 0;
    other_errs = 0;
    rd_pending = 1'b0;
    exp_word   = '0;
    wr_en      = 1'b0;
    rd_en      = 1'b0;
    wr_data    = '0;
    wr_rst_n   = 1'b0;
    rd_rst_n   = 1'b0;
    repeat (8) @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    rd_rst_n <= 1'b1;
    repeat (2) @(posedge wr_clk);

    test_reset();
    test_fill();
    test_drain();
    test_thresholds();
    test_stream();

    $display("Errors: data %0d, flag %0d, count %0d, other %0d",
             data_errs, flag_errs, count_errs, other_errs);
    if (data_errs + flag_errs + count_errs + other_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo import async_fifo_pkg::*; (
  // Write side
  input  logic       wr_clk,
  input  logic       wr_rst_n,
  input  logic       wr_en,
  input  fifo_data_t wr_data,
  // Read side
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_en,
  output fifo_data_t rd_data,
  // Status flags
  output logic       full,
  output logic       afull,
  output logic       empty,
  output logic       aempty
);

  fifo_ptr_t wr_gray;  // Launched from wr_clk flops
  fifo_ptr_t rd_gray;  // Launched from rd_clk flops

  fifo_mem_if mem_if ();

  assign mem_if.wr_data = wr_data;
  assign rd_data        = mem_if.rd_data;

  fifo_wr_ctrl fifo_wr_ctrl_inst (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .rd_gray  (rd_gray),
    .wr_gray  (wr_gray),
    .full     (full),
    .afull    (afull),
    .mem      (mem_if.writer)
  );

  fifo_rd_ctrl fifo_rd_ctrl_inst (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .wr_gray  (wr_gray),
    .rd_gray  (rd_gray),
    .empty    (empty),
    .aempty   (aempty),
    .mem      (mem_if.reader)
  );

  // Storage, written on wr_clk and read on rd_clk
  dualport_ram_async dualport_ram_inst (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .mem      (mem_if.ram)
  );

endmodule

`default_nettype wire

// ==== verilog/fifo_rd_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "async_fifo_defs.svh"

module fifo_rd_ctrl import async_fifo_pkg::*; (
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_en,
  input  fifo_ptr_t  wr_gray,
  output fifo_ptr_t  rd_gray,
  output logic       empty,
  output logic       aempty,
  fifo_mem_if.reader mem
);

  localparam int unsigned MSB = `FIFO_ADDR_WIDTH;

  logic      rd_vld;
  fifo_ptr_t rd_ptr;
  fifo_ptr_t rd_ptr_nxt;
  fifo_ptr_t rd_gray_nxt;
  fifo_ptr_t wr_gray_sync1;
  fifo_ptr_t wr_gray_sync2;
  fifo_ptr_t wr_ptr_sync;
  fifo_ptr_t fill_nxt;

  assign rd_vld = rd_en & ~empty;  // Reads while empty are ignored

  always_comb begin
    if (rd_vld) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr <= '0;
    end else begin
      rd_ptr <= rd_ptr_nxt;
    end
  end

  assign rd_gray_nxt = ptr_bin2gray(rd_ptr_nxt);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_gray <= '0;
    end else begin
      rd_gray <= rd_gray_nxt;
    end
  end

  // Write pointer into the rd_clk domain
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_sync1 <= '0;
      wr_gray_sync2 <= '0;
    end else begin
      wr_gray_sync1 <= wr_gray;
      wr_gray_sync2 <= wr_gray_sync1;
    end
  end

  assign wr_ptr_sync = ptr_gray2bin(wr_gray_sync2);

  // Count may lag real writes, so aempty errs high
  assign fill_nxt = wr_ptr_sync - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_gray_nxt == wr_gray_sync2);
      aempty <= (fill_nxt <= fifo_ptr_t'(`FIFO_AEMPTY_LEVEL));
    end
  end

  assign mem.rd_en   = rd_vld;
  assign mem.rd_addr = rd_ptr[MSB-1:0];

endmodule

`default_nettype wire

// ==== verilog/fifo_wr_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "async_fifo_defs.svh"

module fifo_wr_ctrl import async_fifo_pkg::*; (
  input  logic       wr_clk,
  input  logic       wr_rst_n,
  input  logic       wr_en,
  input  fifo_ptr_t  rd_gray,
  output fifo_ptr_t  wr_gray,
  output logic       full,
  output logic       afull,
  fifo_mem_if.writer mem
);

  localparam int unsigned MSB = `FIFO_ADDR_WIDTH;

  logic      wr_vld;
  fifo_ptr_t wr_ptr;
  fifo_ptr_t wr_ptr_nxt;
  fifo_ptr_t wr_gray_nxt;
  fifo_ptr_t rd_gray_sync1;
  fifo_ptr_t rd_gray_sync2;
  fifo_ptr_t rd_ptr_sync;
  fifo_ptr_t full_gray;
  fifo_ptr_t fill_nxt;

  assign wr_vld = wr_en & ~full;  // Writes while full are dropped

  always_comb begin
    if (wr_vld) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr_nxt;
    end
  end

  assign wr_gray_nxt = ptr_bin2gray(wr_ptr_nxt);

  // Registered so only one bit toggles toward rd_clk
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_gray <= '0;
    end else begin
      wr_gray <= wr_gray_nxt;
    end
  end

  // Two-stage synchronizer for the read pointer
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_sync1 <= '0;
      rd_gray_sync2 <= '0;
    end else begin
      rd_gray_sync1 <= rd_gray;
      rd_gray_sync2 <= rd_gray_sync1;
    end
  end

  assign rd_ptr_sync = ptr_gray2bin(rd_gray_sync2);

  // One full lap ahead means the top two Gray bits differ
  assign full_gray = {~rd_gray_sync2[MSB -: 2], rd_gray_sync2[MSB-2:0]};

  assign fill_nxt = wr_ptr_nxt - rd_ptr_sync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_gray_nxt == full_gray);
      afull <= (fill_nxt >= fifo_ptr_t'(`FIFO_AFULL_LEVEL));
    end
  end

  assign mem.wr_en   = wr_vld;
  assign mem.wr_addr = wr_ptr[MSB-1:0];  // Wrap bit stays out of the RAM

endmodule

`default_nettype wire

// ==== verilog/dualport_ram_async.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "async_fifo_defs.svh"

module dualport_ram_async import async_fifo_pkg::*; (
  input  logic    wr_clk,
  input  logic    rd_clk,
  input  logic    rd_rst_n,
  fifo_mem_if.ram mem
);

  fifo_data_t ram_q [`FIFO_DEPTH];

  // Write port, wr_clk domain
  always_ff @(posedge wr_clk) begin
    if (mem.wr_en) begin
      ram_q[mem.wr_addr] <= mem.wr_data;
    end
  end

  // Read port holds its word until the next accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      mem.rd_data <= '0;
    end else if (mem.rd_en) begin
      mem.rd_data <= ram_q[mem.rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fifo_mem_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface fifo_mem_if import async_fifo_pkg::*; ();

  logic       wr_en;    // Qualified write strobe
  fifo_addr_t wr_addr;
  fifo_data_t wr_data;
  logic       rd_en;    // Qualified read strobe
  fifo_addr_t rd_addr;
  fifo_data_t rd_data;  // Registered RAM output

  modport writer (
    output wr_en,
    output wr_addr,
    input  wr_data
  );

  modport reader (
    output rd_en,
    output rd_addr
  );

  modport ram (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

// ==== verilog/async_fifo_pkg.sv ====
`default_nettype none

`include "async_fifo_defs.svh"

package async_fifo_pkg;

  typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;  // One stored word
  typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_addr_t;  // RAM address
  typedef logic [`FIFO_ADDR_WIDTH:0]   fifo_ptr_t;   // Address plus wrap bit

  function automatic fifo_ptr_t ptr_bin2gray(input fifo_ptr_t bin);
    return (bin >> 1) ^ bin;
  endfunction

  function automatic fifo_ptr_t ptr_gray2bin(input fifo_ptr_t gray);
    fifo_ptr_t bin;
    bin[`FIFO_ADDR_WIDTH] = gray[`FIFO_ADDR_WIDTH];
    for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];  // Fold down from the MSB
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// ==== include/async_fifo_defs.svh ====
`ifndef ASYNC_FIFO_DEFS_SVH
`define ASYNC_FIFO_DEFS_SVH

// Word width in bits
`define FIFO_DATA_WIDTH 8

// Depth must stay a power of two
`define FIFO_DEPTH 16

// Base-two log of FIFO_DEPTH
`define FIFO_ADDR_WIDTH 4

// Fill count at or above which afull rises
`define FIFO_AFULL_LEVEL 14

// Fill count at or below which aempty rises
`define FIFO_AEMPTY_LEVEL 2

`endif
